/* source/dmaPkg.sv */
package dmaPkg;

  localparam int AddrW = 32;
  localparam int CountW = 14;

  typedef enum logic [1:0] {
    Inc,
    Dec,
    Fixed,
    IncReload
  } AddrModeE;

  typedef enum logic [1:0] {
    Immediate,
    VBlank,
    HBlank,
    Special  // audio FIFO request on FIFO channels
  } StartModeE;

  typedef enum logic [1:0] {
    SrcReg,
    DstReg,
    CntReg,
    CtrlReg
  } RegSelE;

  typedef struct packed {
    logic       enable;    // bit 15
    logic       irqEn;
    StartModeE  timing;
    logic       word;      // 1 = 32-bit units, 0 = halfwords
    logic       repeatEn;
    AddrModeE   srcMode;
    AddrModeE   dstMode;
    logic [5:0] reserved;
  } dmaCtrlT;

  typedef struct packed {
    logic [AddrW-1:0]  src;
    logic [AddrW-1:0]  dst;
    logic [CountW-1:0] count;  // 0 means 16384 units
    dmaCtrlT           ctrl;
  } chanCfgT;

  typedef struct packed {
    logic             valid;
    logic             wr;
    logic             word;
    logic [AddrW-1:0] addr;
    logic [31:0]      wdata;
  } busReqT;

endpackage

/* source/dmaRegFile.sv */
`timescale 1ns/1ps

module dmaRegFile #(
  parameter int NumChan = 4
) (
  input  logic                       clk,
  input  logic                       rst_b,
  input  logic                       regWr,
  input  logic [$clog2(NumChan)-1:0] regChan,
  input  dmaPkg::RegSelE             regSel,
  input  logic [dmaPkg::AddrW-1:0]   regData,
  input  logic [NumChan-1:0]         done,
  output dmaPkg::chanCfgT            cfg [NumChan],
  output logic [NumChan-1:0]         load
);
  import dmaPkg::*;

  dmaCtrlT newCtrl;

  assign newCtrl = dmaCtrlT'(regData[15:0]);

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      for (int i = 0; i < NumChan; i++) begin
        cfg[i] <= '0;
      end
      load <= '0;
    end else begin
      for (int i = 0; i < NumChan; i++) begin
        load[i] <= 1'b0;
        if (done[i] && !cfg[i].ctrl.repeatEn) begin
          cfg[i].ctrl.enable <= 1'b0;  // one-shot transfer finished
        end
        if (regWr && int'(regChan) == i) begin  // cpu write wins over the clear
          case (regSel)
            SrcReg: cfg[i].src <= regData;
            DstReg: cfg[i].dst <= regData;
            CntReg: cfg[i].count <= regData[CountW-1:0];
            CtrlReg: begin
              cfg[i].ctrl <= newCtrl;
              load[i] <= newCtrl.enable && !cfg[i].ctrl.enable;  // rising enable
            end
            default: ;
          endcase
        end
      end
    end
  end

endmodule

/* source/dmaStartSel.sv */
`timescale 1ns/1ps

module dmaStartSel (
  input  logic              clk,
  input  logic              rst_b,
  input  dmaPkg::StartModeE timing,
  input  logic              hblank,
  input  logic              vblank,
  input  logic              fifoReq,
  input  logic              isFifo,
  output logic              start
);
  import dmaPkg::*;

  logic armed;

  // special mode without a FIFO acts as an immediate start, one cycle late
  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      armed <= 1'b0;
    end else begin
      armed <= (timing == Special) && !isFifo;
    end
  end

  always_comb begin
    case (timing)
      Immediate: start = 1'b1;
      VBlank:    start = vblank;
      HBlank:    start = hblank;
      default:   start = isFifo ? fifoReq : armed;
    endcase
  end

endmodule

/* source/dmaChannelFsm.sv */
`timescale 1ns/1ps

module dmaChannelFsm (
  input  logic clk,
  input  logic rst_b,
  input  logic load,
  input  logic enable,
  input  logic start,
  input  logic memWait,
  input  logic preempt,
  input  logic mayBegin,
  input  logic lastUnit,
  input  logic repeatEn,
  input  logic irqEn,
  output logic loadAddr,
  output logic stepSrc,
  output logic stepDst,
  output logic latchData,
  output logic rd,
  output logic wr,
  output logic hold,
  output logic done,
  output logic irq
);

  typedef enum logic [2:0] {
    Off,
    Idle,
    Queued,
    Read,
    Write,
    PreemptedRead
  } stateE;

  stateE state;
  stateE nextState;
  logic  free;
  logic  unitDone;

  assign free = !preempt && mayBegin && !memWait;
  assign unitDone = (state == Write) && !memWait;

  assign rd = (state == Read);
  assign wr = (state == Write);
  assign hold = rd || (wr && memWait);  // unit in flight until its write completes
  assign latchData = rd && !preempt && !memWait;
  assign stepSrc = latchData;
  assign stepDst = unitDone;
  assign done = unitDone && lastUnit;
  assign loadAddr = ((state == Off) && load) || (done && repeatEn);  // repeat reloads count

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      state <= Off;
      irq <= 1'b0;
    end else begin
      state <= nextState;
      irq <= done && irqEn;
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      Off: begin
        if (load) begin
          nextState = Idle;
        end
      end
      Idle: begin
        if (!enable) begin
          nextState = Off;
        end else if (start) begin
          nextState = free ? Read : Queued;
        end
      end
      Queued, PreemptedRead: begin
        if (!enable) begin
          nextState = Off;
        end else if (free) begin
          nextState = Read;
        end
      end
      Read: begin
        if (preempt) begin
          nextState = PreemptedRead;  // lost a same-cycle begin, read not taken
        end else if (!memWait) begin
          nextState = Write;
        end
      end
      Write: begin
        if (!memWait) begin
          if (lastUnit) begin
            nextState = repeatEn ? Idle : Off;
          end else if (preempt) begin
            nextState = PreemptedRead;
          end else begin
            nextState = Read;
          end
        end
      end
      default: nextState = Off;
    endcase
  end

endmodule

/* source/dmaChannelPath.sv */
`timescale 1ns/1ps

module dmaChannelPath (
  input  logic                     clk,
  input  logic                     rst_b,
  input  dmaPkg::chanCfgT          cfg,
  input  logic                     isFifo,
  input  logic                     loadAddr,
  input  logic                     stepSrc,
  input  logic                     stepDst,
  input  logic                     latchData,
  input  logic                     rd,
  input  logic                     wr,
  input  logic [31:0]              memRdata,
  output logic                     lastUnit,
  output dmaPkg::busReqT           req
);
  import dmaPkg::*;

  logic [AddrW-1:0]  srcAddr;
  logic [AddrW-1:0]  dstAddr;
  logic [CountW-1:0] unitCnt;
  logic [31:0]       rdLatch;
  logic              fifoMode;
  logic              wordSize;
  AddrModeE          dstMode;
  logic [AddrW-1:0]  unitStep;
  logic              reloadDst;

  function automatic logic [AddrW-1:0] stepAddr(input logic [AddrW-1:0] addr,
                                                input AddrModeE mode,
                                                input logic [AddrW-1:0] delta);
    case (mode)
      Dec:     return addr - delta;
      Fixed:   return addr;
      default: return addr + delta;  // Inc and IncReload
    endcase
  endfunction

  assign fifoMode = isFifo && (cfg.ctrl.timing == Special);
  assign wordSize = cfg.ctrl.word || fifoMode;
  assign dstMode = fifoMode ? Fixed : cfg.ctrl.dstMode;
  assign unitStep = wordSize ? AddrW'(4) : AddrW'(2);
  // a load during the final write is a repeat: count always, dst only for reload mode
  assign reloadDst = loadAddr && (!wr || dstMode == IncReload);

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      srcAddr <= '0;
      dstAddr <= '0;
      unitCnt <= '0;
    end else begin
      if (loadAddr && !wr) begin
        srcAddr <= cfg.src;
      end else if (stepSrc) begin
        srcAddr <= stepAddr(srcAddr, cfg.ctrl.srcMode, unitStep);
      end
      if (reloadDst) begin
        dstAddr <= cfg.dst;
      end else if (stepDst) begin
        dstAddr <= stepAddr(dstAddr, dstMode, unitStep);
      end
      if (loadAddr) begin
        unitCnt <= '0;
      end else if (stepDst) begin
        unitCnt <= unitCnt + CountW'(1);
      end
    end
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      rdLatch <= '0;
    end else if (latchData) begin
      rdLatch <= memRdata;
    end
  end

  assign lastUnit = (unitCnt == cfg.count - CountW'(1));  // count 0 wraps to 16384

  always_comb begin
    req.valid = rd || wr;
    req.wr = wr;
    req.word = wordSize;
    req.addr = wr ? dstAddr : srcAddr;
    req.wdata = rdLatch;
  end

endmodule

/* source/dmaArbiter.sv */
`timescale 1ns/1ps

module dmaArbiter #(
  parameter int NumChan = 4
) (
  input  dmaPkg::busReqT     reqs [NumChan],
  input  logic [NumChan-1:0] hold,
  output logic [NumChan-1:0] preempt,
  output logic               mayBegin,
  output dmaPkg::busReqT     memReq
);

  logic lowerBusy;

  // a channel is preempted by any lower-numbered channel on the bus
  always_comb begin
    lowerBusy = 1'b0;
    for (int i = 0; i < NumChan; i++) begin
      preempt[i] = lowerBusy;
      lowerBusy = lowerBusy || reqs[i].valid;
    end
  end

  assign mayBegin = ~|hold;

  // scan from the top so the lowest valid channel ends up on the bus
  always_comb begin
    memReq = '0;
    for (int i = NumChan - 1; i >= 0; i--) begin
      if (reqs[i].valid) begin
        memReq = reqs[i];
      end
    end
  end

endmodule

/* source/dmaTop.sv */
`timescale 1ns/1ps

module dmaTop #(
  parameter int                 NumChan     = 4,
  parameter logic [NumChan-1:0] SpecialFifo = NumChan'(4'b0110)
) (
  input  logic                       clk,
  input  logic                       rst_b,
  input  logic                       regWr,
  input  logic [$clog2(NumChan)-1:0] regChan,
  input  dmaPkg::RegSelE             regSel,
  input  logic [dmaPkg::AddrW-1:0]   regData,
  input  logic                       hblank,
  input  logic                       vblank,
  input  logic [NumChan-1:0]         fifoReq,
  input  logic                       memWait,
  input  logic [31:0]                memRdata,
  output dmaPkg::busReqT             memReq,
  output logic [NumChan-1:0]         irq
);
  import dmaPkg::*;

  chanCfgT            cfg [NumChan];
  busReqT             reqs [NumChan];
  logic [NumChan-1:0] load;
  logic [NumChan-1:0] done;
  logic [NumChan-1:0] hold;
  logic [NumChan-1:0] preempt;
  logic               mayBegin;

  dmaRegFile #(.NumChan(NumChan)) regFile (
    .clk, .rst_b, .regWr, .regChan, .regSel, .regData, .done, .cfg, .load
  );

  dmaArbiter #(.NumChan(NumChan)) arbiter (
    .reqs, .hold, .preempt, .mayBegin, .memReq
  );

  for (genvar i = 0; i < NumChan; i++) begin : chan
    logic start;
    logic loadAddr;
    logic stepSrc;
    logic stepDst;
    logic latchData;
    logic rd;
    logic wr;
    logic lastUnit;

    dmaStartSel startSel (
      .clk, .rst_b, .timing(cfg[i].ctrl.timing), .hblank, .vblank,
      .fifoReq(fifoReq[i]), .isFifo(SpecialFifo[i]), .start
    );

    dmaChannelFsm fsm (
      .clk, .rst_b, .load(load[i]), .enable(cfg[i].ctrl.enable), .start, .memWait,
      .preempt(preempt[i]), .mayBegin, .lastUnit, .repeatEn(cfg[i].ctrl.repeatEn),
      .irqEn(cfg[i].ctrl.irqEn), .loadAddr, .stepSrc, .stepDst, .latchData, .rd, .wr,
      .hold(hold[i]), .done(done[i]), .irq(irq[i])
    );

    dmaChannelPath path (
      .clk, .rst_b, .cfg(cfg[i]), .isFifo(SpecialFifo[i]), .loadAddr, .stepSrc,
      .stepDst, .latchData, .rd, .wr, .memRdata, .lastUnit, .req(reqs[i])
    );
  end

endmodule

/* verification/dma_asserts.sv */
`timescale 1ns/1ps

module dma_asserts (
  input logic clk,
  input logic rst_b,
  input logic rd,
  input logic wr,
  input logic memWait,
  input logic preempt,
  input logic irq
);

  // a lower channel never gets the bus between a read and its write
  pairNotSplit: assert property (@(posedge clk) disable iff (!rst_b) wr |-> !preempt)
    else $error("write of a unit preempted by a lower channel");

  // a stalled request keeps its phase until memWait drops
  readHeld: assert property (@(posedge clk) disable iff (!rst_b)
    (rd && memWait && !preempt) |=> rd)
    else $error("read request dropped while memWait high");

  writeHeld: assert property (@(posedge clk) disable iff (!rst_b) (wr && memWait) |=> wr)
    else $error("write request dropped while memWait high");

  irqPulse: assert property (@(posedge clk) disable iff (!rst_b) irq |=> !irq)
    else $error("irq longer than one cycle");

endmodule

bind dmaChannelFsm dma_asserts fsmAsserts (.clk, .rst_b, .rd, .wr, .memWait, .preempt, .irq);

/* verification/dmaTb.sv */
`timescale 1ns/1ps

module dmaTb;
  import dmaPkg::*;

  localparam int NumChan = 4;

  logic               clk;
  logic               rst_b;
  logic               regWr;
  logic [1:0]         regChan;
  RegSelE             regSel;
  logic [31:0]        regData;
  logic               hblank;
  logic               vblank;
  logic [NumChan-1:0] fifoReq;
  logic               memWait;
  logic [31:0]        memRdata;
  busReqT             memReq;
  logic [NumChan-1:0] irq;

  logic [31:0] mem [256];
  logic [31:0] expAddr [NumChan][$];  // pending writes per channel, in order
  logic [31:0] expData [NumChan][$];
  logic        expWord [NumChan];
  int gotCnt [NumChan];
  int irqCnt [NumChan];
  int errors = 0;
  int caseErr = 0;
  int caseNo = 0;
  int failedCases = 0;
  int cycles = 0;
  int limit = 32'h7fff_ffff;
  int waitMode = 0;

  dmaTop #(.NumChan(NumChan)) DUT (
    .clk, .rst_b, .regWr, .regChan, .regSel, .regData, .hblank, .vblank,
    .fifoReq, .memWait, .memRdata, .memReq, .irq
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    while (cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: run stopped after %0d cycles", cycles);
    $display("Simulation FAILED");
    $finish;
  end

  // memory content mixes the stored word with the full address
  function automatic logic [31:0] memData(logic [31:0] addr);
    return mem[addr[9:2]] ^ {addr[15:0], addr[31:16]};
  endfunction

  function automatic logic [31:0] nextAddr(logic [31:0] a, logic [1:0] mode, logic [31:0] step);
    case (mode)
      2'd1:    return a - step;  // decrement
      2'd2:    return a;         // fixed
      default: return a + step;
    endcase
  endfunction

  function automatic bit allWritten();
    for (int i = 0; i < NumChan; i++) begin
      if (expAddr[i].size() != 0) return 1'b0;
    end
    return 1'b1;
  endfunction

  task automatic check(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      $display("error at %0t: %s = %h, expected %h", $time, name, got, exp);
      errors++;
      caseErr++;
    end
  endtask

  task automatic nextCycle();
    @(posedge clk);
    #1;
  endtask

  task automatic regWrite(int ch, RegSelE sel, logic [31:0] data);
    nextCycle();
    regWr = 1'b1;
    regChan = 2'(ch);
    regSel = sel;
    regData = data;
    nextCycle();
    regWr = 1'b0;
  endtask

  task automatic buildExpected(int ch, logic [31:0] src, logic [31:0] dst, int cnt,
                               logic [31:0] ctrl, int runs);
    logic [31:0] s;
    logic [31:0] d;
    logic [31:0] step;
    logic        fifo;
    logic [1:0]  dMode;
    fifo = (ch == 1 || ch == 2) && (ctrl[13:12] == 2'd3);
    step = (ctrl[11] || fifo) ? 32'd4 : 32'd2;
    dMode = fifo ? 2'd2 : ctrl[7:6];
    expWord[ch] = ctrl[11] || fifo;
    s = src;
    d = dst;
    for (int r = 0; r < runs; r++) begin
      for (int u = 0; u < cnt; u++) begin
        expAddr[ch].push_back(d);
        expData[ch].push_back(memData(s));
        s = nextAddr(s, ctrl[9:8], step);
        d = nextAddr(d, dMode, step);
      end
      if (dMode == 2'd3) d = dst;  // reload mode restores dst each run
    end
  endtask

  // memory side: random wait and read data driven just after the edge
  initial begin
    memWait = 1'b0;
    memRdata = '0;
    forever begin
      @(posedge clk);
      #1;
      memWait = (waitMode != 0) && ($urandom % 3 == 0);
      memRdata = memData(memReq.addr);
    end
  end

  always @(negedge clk) begin
    int ch;
    if (rst_b) begin
      for (int i = 0; i < NumChan; i++) irqCnt[i] += int'(irq[i]);
      if (memReq.valid && memReq.wr && !memWait) begin
        ch = 0;
        while (ch < NumChan - 1 && !DUT.reqs[ch].valid) ch++;  // lowest valid owns the bus
        if (expAddr[ch].size() == 0) begin
          $display("unexpected write from channel %0d at %0t", ch, $time);
          errors++;
          caseErr++;
        end else begin
          check("memReq.addr", memReq.addr, expAddr[ch].pop_front());
          check("memReq.wdata", memReq.wdata, expData[ch].pop_front());
          check("memReq.word", 32'(memReq.word), 32'(expWord[ch]));
          gotCnt[ch]++;
        end
      end
    end
  end

  task automatic computeLimit();
    int    fd;
    int    a;
    int    b;
    int    c;
    int    len;
    int    total;
    string line;
    total = 0;
    fd = $fopen("verification/dmaCases.txt", "r");
    if (fd != 0) begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() > 0 && line.substr(0, 0) == "c") begin
          if ($sscanf(line, "c %d %d %d %d", a, b, c, len) == 4) total += len;
        end
      end
      $fclose(fd);
    end
    limit = total * 4 + 200;
  endtask

  task automatic runCases(int fd);
    string       line;
    int          strobe;
    int          nStrobe;
    int          len;
    int          ch;
    int          cnt;
    int          runs;
    int          irqExp;
    int          delay;
    int          waited;
    logic [31:0] src;
    logic [31:0] dst;
    logic [31:0] ctrl;
    int          chans [$];
    int          expIrq [NumChan];
    int          units [NumChan];
    logic        isRep [NumChan];
    while ($fgets(line, fd) != 0) begin
      if (line.len() == 0 || line.substr(0, 0) == "#") continue;
      if (line.substr(0, 0) == "c") begin
        void'($sscanf(line, "c %d %d %d %d", waitMode, strobe, nStrobe, len));
        caseNo++;
        caseErr = 0;
        chans.delete();
        for (int i = 0; i < NumChan; i++) begin
          gotCnt[i] = 0;
          irqCnt[i] = 0;
        end
      end else if (line.substr(0, 0) == "w") begin
        void'($sscanf(line, "w %d %h %h %d %h %d %d %d", ch, src, dst, cnt, ctrl, runs,
                      irqExp, delay));
        chans.push_back(ch);
        expIrq[ch] = irqExp;
        units[ch] = cnt;
        isRep[ch] = ctrl[10];
        buildExpected(ch, src, dst, cnt, ctrl, runs);
        repeat (delay) nextCycle();
        regWrite(ch, SrcReg, src);
        regWrite(ch, DstReg, dst);
        regWrite(ch, CntReg, 32'(cnt));
        regWrite(ch, CtrlReg, ctrl);
      end else if (line.substr(0, 0) == "e") begin
        for (int s = 0; s < nStrobe; s++) begin
          repeat (40) nextCycle();
          // each strobe so far has run exactly one block of units
          foreach (chans[k]) begin
            check("writes before strobe", 32'(gotCnt[chans[k]]), 32'(s * units[chans[k]]));
          end
          case (strobe)
            1:       vblank = 1'b1;
            2:       hblank = 1'b1;
            default: fifoReq = '1;
          endcase
          nextCycle();
          vblank = 1'b0;
          hblank = 1'b0;
          fifoReq = '0;
        end
        waited = 0;
        while (!allWritten() && waited < len) begin
          nextCycle();
          waited++;
        end
        if (!allWritten()) begin
          $display("case %0d: transfers did not finish within %0d cycles", caseNo, len);
          errors++;
          caseErr++;
        end
        repeat (4) nextCycle();
        foreach (chans[k]) begin
          ch = chans[k];
          check("irq count", 32'(irqCnt[ch]), 32'(expIrq[ch]));
          if (!isRep[ch]) check("ctrl.enable", 32'(DUT.regFile.cfg[ch].ctrl.enable), 0);
          regWrite(ch, CtrlReg, 0);  // park repeating channels
          expAddr[ch].delete();
          expData[ch].delete();
        end
        waitMode = 0;
        if (caseErr == 0) begin
          $display("case %0d ok", caseNo);
        end else begin
          $display("case %0d failed with %0d errors", caseNo, caseErr);
          failedCases++;
        end
      end
    end
  endtask

  initial begin
    int fd;
    rst_b = 1'b0;
    regWr = 1'b0;
    regChan = '0;
    regSel = SrcReg;
    regData = '0;
    hblank = 1'b0;
    vblank = 1'b0;
    fifoReq = '0;
    void'($urandom(32'h36e8_e330));
    for (int i = 0; i < 256; i++) mem[i] = $urandom;
    computeLimit();
    repeat (16) @(posedge clk);
    #1 rst_b = 1'b1;
    fd = $fopen("verification/dmaCases.txt", "r");
    if (fd == 0) begin
      $display("could not open verification/dmaCases.txt");
      errors++;
    end else begin
      runCases(fd);
      $fclose(fd);
    end
    $display("%0d cases run, %0d failed, %0d errors", caseNo, failedCases, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

/* verification/dmaCases.txt */
# c waitMode strobe(0 none, 1 vblank, 2 hblank, 3 fifo) strobeCount maxCycles
# w chan src dst count ctrl runs irqCount delay, then e runs the case
c 0 0 0 120
w 0 00001000 00002000 4 c800 1 1 0
e
c 0 0 0 120
w 1 00001102 00002100 5 c180 1 1 0
e
c 0 1 2 200
w 2 00001200 00002200 3 dcc0 2 2 0
e
c 0 2 3 250
w 3 00001300 00002300 4 e400 3 3 0
e
c 0 0 0 200
w 3 00001400 00002400 12 c800 1 1 0
w 0 00001500 00002500 3 c800 1 1 6
e
c 1 0 0 200
w 2 00001600 00002600 8 c800 1 1 0
e
c 1 0 0 300
w 3 00001740 00002700 10 c900 1 1 0
w 1 00001800 00002800 4 c800 1 1 4
e
c 0 3 3 250
w 1 00001900 000020a0 2 f400 3 3 0
e

/* src.f */
source/dmaPkg.sv
source/dmaRegFile.sv
source/dmaStartSel.sv
source/dmaChannelFsm.sv
source/dmaChannelPath.sv
source/dmaArbiter.sv
source/dmaTop.sv
verification/dma_asserts.sv
verification/dmaTb.sv

/* runSim.sh */
#!/bin/sh
# build and run the DMA testbench, exit status follows the result
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert --top-module dmaTb -f src.f -o simv &&
  ./obj_dir/simv | tee /dev/stderr | grep -q "Simulation PASSED" &&
  echo "run ok" ||
  { echo "run failed"; exit 1; }
